// File: design/if_pkg.sv
// --------------------------------------
// Shared types and constants of the instruction fetch stage.
// Imported by every RTL module of the fetch path.
// --------------------------------------
package if_pkg;

        typedef logic [31:0] addr_t;
        typedef logic [31:0] instr_t;

        // Upper bits of mtvec, the low eight bits are always zero
        typedef logic [23:0] trap_base_t;
        typedef logic [4:0]  exc_cause_t;

        // Redirect sources
        typedef enum logic [2:0] {
                PC_BOOT      = 3'd0,
                PC_JUMP      = 3'd1,
                PC_BRANCH    = 3'd2,
                PC_EXCEPTION = 3'd3,
                PC_MRET      = 3'd4
        } pc_mux_e;

        typedef enum logic {
                EXC_PC_EXCEPTION = 1'b0,
                EXC_PC_IRQ       = 1'b1
        } exc_pc_mux_e;

        // One fetched word with the address it came from
        typedef struct packed {
                addr_t  addr;
                instr_t rdata;
        } fetch_entry_t;

        // --------------------------------------
        // Buffer sizing
        // --------------------------------------
        localparam int FIFO_DEPTH      = 2;
        localparam int MAX_OUTSTANDING = 2;
        localparam int CNT_W           = 2;

endpackage

// File: design/pc_select.sv
// --------------------------------------
// Next fetch address selection on a redirect.
// Combinational, valid in the pc_set_i cycle.
// --------------------------------------
module pc_select
        import if_pkg::*;
(
        input  logic            pc_set_i,
        input  pc_mux_e         pc_mux_i,
        input  exc_pc_mux_e     exc_pc_mux_i,
        input  addr_t           boot_addr_i,
        input  addr_t           jump_target_id_i,
        input  addr_t           jump_target_ex_i,
        input  addr_t           mepc_i,
        input  trap_base_t      m_trap_base_addr_i,
        input  exc_cause_t      m_exc_vec_pc_mux_i,
        output addr_t           branch_addr_o,
        output logic            csr_mtvec_init_o
);
        addr_t  trap_addr;
        addr_t  target;

        // Vectored mode only for interrupts, base + 4 * cause
        always_comb begin
                if (exc_pc_mux_i == EXC_PC_IRQ) begin
                        trap_addr = {m_trap_base_addr_i, 1'b0, m_exc_vec_pc_mux_i, 2'b00};
                end else begin
                        trap_addr = {m_trap_base_addr_i, 8'h00};
                end
        end

        always_comb begin
                case (pc_mux_i)
                        PC_BOOT:      target = boot_addr_i;
                        PC_JUMP:      target = jump_target_id_i;
                        PC_BRANCH:    target = jump_target_ex_i;
                        PC_EXCEPTION: target = trap_addr;
                        PC_MRET:      target = mepc_i;
                        default:      target = boot_addr_i;
                endcase
        end

        // Fetches are word-aligned
        assign branch_addr_o = {target[31:2], 2'b00};

        // CSR unit loads its trap base on the boot redirect
        assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

endmodule

// File: design/fetch_fifo.sv
// --------------------------------------
// Small FIFO of fetched address/word pairs.
// Flush empties it in one cycle and wins over a push.
// --------------------------------------
module fetch_fifo
        import if_pkg::*;
(
        input  logic                    clk,
        input  logic                    reset_i,
        input  logic                    flush_i,
        input  logic                    push_i,
        input  fetch_entry_t            push_entry_i,
        input  logic                    pop_i,
        output logic                    valid_o,
        output fetch_entry_t            entry_o,
        output logic [CNT_W-1:0]        count_o
);
        fetch_entry_t                           mem_q [FIFO_DEPTH];
        logic [$clog2(FIFO_DEPTH)-1:0]          wr_ptr_q;
        logic [$clog2(FIFO_DEPTH)-1:0]          rd_ptr_q;
        logic [CNT_W-1:0]                       count_q;
        logic                                   full;
        logic                                   do_push;
        logic                                   do_pop;

        assign full    = (count_q == CNT_W'(FIFO_DEPTH));
        assign do_pop  = pop_i && valid_o;
        assign do_push = push_i && (!full || do_pop);

        assign valid_o = (count_q != '0);
        assign entry_o = mem_q[rd_ptr_q];
        assign count_o = count_q;

        // Pointers wrap at the power-of-two depth
        always_ff @(posedge clk) begin
                if (reset_i || flush_i) begin
                        wr_ptr_q <= '0;
                        rd_ptr_q <= '0;
                        count_q  <= '0;
                end else begin
                        if (do_push) begin
                                wr_ptr_q <= wr_ptr_q + 1'b1;
                        end
                        if (do_pop) begin
                                rd_ptr_q <= rd_ptr_q + 1'b1;
                        end
                        count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
                end
        end

        always_ff @(posedge clk) begin
                if (do_push) begin
                        mem_q[wr_ptr_q] <= push_entry_i;
                end
        end

endmodule

// File: design/prefetch_buffer.sv
// --------------------------------------
// Issues instruction bus requests and buffers the responses.
// Responses that belong to a stream left by a branch are dropped.
// --------------------------------------
module prefetch_buffer
        import if_pkg::*;
(
        input  logic            clk,
        input  logic            reset_i,
        input  logic            req_i,
        input  logic            branch_i,
        input  addr_t           branch_addr_i,
        input  logic            fetch_ready_i,
        output logic            fetch_valid_o,
        output fetch_entry_t    fetch_entry_o,
        output logic            instr_req_o,
        output addr_t           instr_addr_o,
        input  logic            instr_gnt_i,
        input  logic            instr_rvalid_i,
        input  instr_t          instr_rdata_i,
        output logic            busy_o
);
        addr_t                                  fetch_addr_q;
        addr_t                                  stale_addr_q;
        logic                                   active_q;
        logic                                   pend_q;
        logic                                   stale_q;
        logic [CNT_W-1:0]                       out_cnt_q;
        logic [CNT_W-1:0]                       out_cnt_d;
        logic [CNT_W-1:0]                       disc_cnt_q;
        logic [CNT_W-1:0]                       live_cnt;
        logic [CNT_W-1:0]                       fifo_count;
        logic [CNT_W:0]                         fill;
        addr_t                                  aq_q [MAX_OUTSTANDING];
        logic [$clog2(MAX_OUTSTANDING)-1:0]     aq_wr_q;
        logic [$clog2(MAX_OUTSTANDING)-1:0]     aq_rd_q;
        logic                                   start_ok;
        logic                                   gnt_ev;
        logic                                   drop;
        logic                                   push;
        fetch_entry_t                           push_entry;

        // --------------------------------------
        // Request side
        // --------------------------------------
        // Only responses that will reach the FIFO count against its space
        assign live_cnt = out_cnt_q - disc_cnt_q;
        assign fill     = {1'b0, fifo_count} + {1'b0, live_cnt};
        assign start_ok = active_q && req_i && !branch_i &&
                          (out_cnt_q < CNT_W'(MAX_OUTSTANDING)) &&
                          (fill < (CNT_W+1)'(FIFO_DEPTH));

        // An ungranted request stays on the bus, even across a branch
        assign instr_req_o  = pend_q || start_ok;
        assign instr_addr_o = stale_q ? stale_addr_q : fetch_addr_q;
        assign gnt_ev       = instr_req_o && instr_gnt_i;

        // --------------------------------------
        // Response side
        // --------------------------------------
        assign out_cnt_d  = out_cnt_q + CNT_W'(gnt_ev) - CNT_W'(instr_rvalid_i);
        assign drop       = instr_rvalid_i && (disc_cnt_q != '0);
        assign push       = instr_rvalid_i && !drop;
        assign push_entry = '{addr: aq_q[aq_rd_q], rdata: instr_rdata_i};

        assign busy_o = pend_q || (out_cnt_q != '0) || fetch_valid_o;

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        active_q     <= 1'b0;
                        pend_q       <= 1'b0;
                        stale_q      <= 1'b0;
                        fetch_addr_q <= '0;
                        out_cnt_q    <= '0;
                        disc_cnt_q   <= '0;
                        aq_wr_q      <= '0;
                        aq_rd_q      <= '0;
                end else begin
                        pend_q    <= instr_req_o && !instr_gnt_i;
                        out_cnt_q <= out_cnt_d;
                        if (branch_i) begin
                                // Everything still in flight is from the old stream
                                active_q     <= 1'b1;
                                fetch_addr_q <= branch_addr_i;
                                disc_cnt_q   <= out_cnt_d;
                        end else begin
                                if (gnt_ev && !stale_q) begin
                                        fetch_addr_q <= fetch_addr_q + 32'd4;
                                end
                                disc_cnt_q <= disc_cnt_q + CNT_W'(gnt_ev && stale_q)
                                              - CNT_W'(drop);
                        end
                        if (gnt_ev) begin
                                stale_q <= 1'b0;
                        end else if (branch_i && instr_req_o) begin
                                stale_q <= 1'b1;
                        end
                        if (gnt_ev) begin
                                aq_wr_q <= aq_wr_q + 1'b1;
                        end
                        if (instr_rvalid_i) begin
                                aq_rd_q <= aq_rd_q + 1'b1;
                        end
                end
        end

        // Address of a held request and addresses of granted ones
        always_ff @(posedge clk) begin
                if (branch_i && instr_req_o && !gnt_ev) begin
                        stale_addr_q <= instr_addr_o;
                end
                if (gnt_ev) begin
                        aq_q[aq_wr_q] <= instr_addr_o;
                end
        end

        fetch_fifo u_fetch_fifo (
                .clk            (clk),
                .reset_i        (reset_i),
                .flush_i        (branch_i),
                .push_i         (push),
                .push_entry_i   (push_entry),
                .pop_i          (fetch_ready_i),
                .valid_o        (fetch_valid_o),
                .entry_o        (fetch_entry_o),
                .count_o        (fifo_count)
        );

endmodule

// File: design/if_id_register.sv
// --------------------------------------
// IF/ID pipeline register toward decode.
// Holds while decode stalls, cleared by a branch.
// --------------------------------------
module if_id_register
        import if_pkg::*;
(
        input  logic            clk,
        input  logic            reset_i,
        input  logic            branch_i,
        input  logic            fetch_valid_i,
        input  fetch_entry_t    fetch_entry_i,
        output logic            fetch_ready_o,
        input  logic            id_ready_i,
        output logic            instr_valid_id_o,
        output instr_t          instr_rdata_id_o,
        output addr_t           pc_id_o
);
        logic   valid_q;
        instr_t rdata_q;
        addr_t  pc_q;
        logic   load;

        // Free when empty or when decode takes the current word
        assign fetch_ready_o = !valid_q || id_ready_i;
        assign load          = fetch_valid_i && fetch_ready_o && !branch_i;

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        valid_q <= 1'b0;
                end else if (branch_i) begin
                        valid_q <= 1'b0;
                end else if (fetch_ready_o) begin
                        valid_q <= fetch_valid_i;
                end
        end

        always_ff @(posedge clk) begin
                if (load) begin
                        rdata_q <= fetch_entry_i.rdata;
                        pc_q    <= fetch_entry_i.addr;
                end
        end

        assign instr_valid_id_o = valid_q;
        assign instr_rdata_id_o = rdata_q;
        assign pc_id_o          = pc_q;

endmodule

// File: design/if_stage.sv
// --------------------------------------
// Instruction fetch stage top level.
// Redirect selection, prefetch buffer and IF/ID register.
// --------------------------------------
module if_stage
        import if_pkg::*;
(
        input  logic            clk,
        input  logic            reset_i,
        input  logic            req_i,

        // Redirect from the controller
        input  logic            pc_set_i,
        input  pc_mux_e         pc_mux_i,
        input  exc_pc_mux_e     exc_pc_mux_i,
        input  addr_t           boot_addr_i,
        input  addr_t           jump_target_id_i,
        input  addr_t           jump_target_ex_i,
        input  addr_t           mepc_i,
        input  trap_base_t      m_trap_base_addr_i,
        input  exc_cause_t      m_exc_vec_pc_mux_i,

        // Instruction bus
        output logic            instr_req_o,
        output addr_t           instr_addr_o,
        input  logic            instr_gnt_i,
        input  logic            instr_rvalid_i,
        input  instr_t          instr_rdata_i,

        // Decode side
        input  logic            id_ready_i,
        output logic            instr_valid_id_o,
        output instr_t          instr_rdata_id_o,
        output addr_t           pc_id_o,

        output logic            csr_mtvec_init_o,
        output logic            if_busy_o
);
        addr_t          branch_addr;
        logic           fetch_valid;
        logic           fetch_ready;
        fetch_entry_t   fetch_entry;

        pc_select u_pc_select (
                .pc_set_i               (pc_set_i),
                .pc_mux_i               (pc_mux_i),
                .exc_pc_mux_i           (exc_pc_mux_i),
                .boot_addr_i            (boot_addr_i),
                .jump_target_id_i       (jump_target_id_i),
                .jump_target_ex_i       (jump_target_ex_i),
                .mepc_i                 (mepc_i),
                .m_trap_base_addr_i     (m_trap_base_addr_i),
                .m_exc_vec_pc_mux_i     (m_exc_vec_pc_mux_i),
                .branch_addr_o          (branch_addr),
                .csr_mtvec_init_o       (csr_mtvec_init_o)
        );

        prefetch_buffer u_prefetch_buffer (
                .clk                    (clk),
                .reset_i                (reset_i),
                .req_i                  (req_i),
                .branch_i               (pc_set_i),
                .branch_addr_i          (branch_addr),
                .fetch_ready_i          (fetch_ready),
                .fetch_valid_o          (fetch_valid),
                .fetch_entry_o          (fetch_entry),
                .instr_req_o            (instr_req_o),
                .instr_addr_o           (instr_addr_o),
                .instr_gnt_i            (instr_gnt_i),
                .instr_rvalid_i         (instr_rvalid_i),
                .instr_rdata_i          (instr_rdata_i),
                .busy_o                 (if_busy_o)
        );

        if_id_register u_if_id_register (
                .clk                    (clk),
                .reset_i                (reset_i),
                .branch_i               (pc_set_i),
                .fetch_valid_i          (fetch_valid),
                .fetch_entry_i          (fetch_entry),
                .fetch_ready_o          (fetch_ready),
                .id_ready_i             (id_ready_i),
                .instr_valid_id_o       (instr_valid_id_o),
                .instr_rdata_id_o       (instr_rdata_id_o),
                .pc_id_o                (pc_id_o)
        );

endmodule

// File: test/if_stage_asserts.sv
// ----------------------------------------
// Instruction bus and occupancy checks, bound into prefetch_buffer.
// ----------------------------------------
module if_stage_asserts
        import if_pkg::*;
(
        input  logic                    clk,
        input  logic                    reset_i,
        input  logic                    req_i,
        input  logic                    gnt_i,
        input  addr_t                   addr_i,
        input  logic [CNT_W-1:0]        out_cnt_i
);
        timeunit 1ns;
        timeprecision 100ps;

        // A request waits on the bus with a fixed address until granted
        req_held: assert property (@(posedge clk) disable iff (reset_i)
                req_i && !gnt_i |=> req_i && $stable(addr_i))
                else $error("instr_req_o dropped or instr_addr_o moved before the grant");

        out_cnt_max: assert property (@(posedge clk) disable iff (reset_i)
                out_cnt_i <= CNT_W'(MAX_OUTSTANDING))
                else $error("more bus transactions outstanding than allowed");

        addr_aligned: assert property (@(posedge clk) disable iff (reset_i)
                addr_i[1:0] == 2'b00)
                else $error("instr_addr_o is not word-aligned");

endmodule

bind prefetch_buffer if_stage_asserts u_if_stage_asserts (
        .clk            (clk),
        .reset_i        (reset_i),
        .req_i          (instr_req_o),
        .gnt_i          (instr_gnt_i),
        .addr_i         (instr_addr_o),
        .out_cnt_i      (out_cnt_q)
);

// File: test/tb_if_stage.sv
// ----------------------------------------
// Testbench for the instruction fetch stage. A memory model with
// random grants and delays serves the bus, a redirect table is
// applied in a loop and every decode handover is checked.
// ----------------------------------------
module tb_if_stage
        import if_pkg::*;
();
        timeunit 1ns;
        timeprecision 100ps;

        localparam addr_t       MEM_KEY          = 32'h5ca1_ab1e;
        localparam int          HANDOVER_TIMEOUT = 200;
        localparam int          DRAIN_TIMEOUT    = 200;
        localparam int          NUM_ROWS         = 9;

        // One redirect and the stream expected after it
        typedef struct packed {
                pc_mux_e        pc_mux;
                exc_pc_mux_e    exc_mux;
                addr_t          operand;
                exc_cause_t     cause;
                int unsigned    ready_pct;
                int unsigned    count;
        } row_t;

        typedef struct packed {
                addr_t          addr;
                int unsigned    due;
        } resp_t;

        // For trap rows the operand holds the 24-bit trap base
        localparam row_t ROWS [NUM_ROWS] = '{
                '{PC_BOOT,      EXC_PC_EXCEPTION, 32'h0000_1000, 5'd0,  100, 12},
                '{PC_JUMP,      EXC_PC_IRQ,       32'h0000_2046, 5'd3,  70,  10},
                '{PC_BRANCH,    EXC_PC_EXCEPTION, 32'h3000_0100, 5'd0,  50,  16},
                '{PC_EXCEPTION, EXC_PC_EXCEPTION, 32'h0000_8000, 5'd7,  80,  6},
                '{PC_EXCEPTION, EXC_PC_IRQ,       32'h0000_8000, 5'd11, 60,  6},
                '{PC_MRET,      EXC_PC_EXCEPTION, 32'h0000_2468, 5'd0,  40,  20},
                '{PC_JUMP,      EXC_PC_EXCEPTION, 32'h0000_5000, 5'd0,  100, 3},
                '{PC_BRANCH,    EXC_PC_EXCEPTION, 32'h0000_6000, 5'd0,  30,  24},
                '{PC_EXCEPTION, EXC_PC_IRQ,       32'h00ab_cdef, 5'd31, 90,  8}
        };

        logic           clk;
        logic           reset_i;
        logic           req_i;
        logic           pc_set_i;
        pc_mux_e        pc_mux_i;
        exc_pc_mux_e    exc_pc_mux_i;
        addr_t          boot_addr_i;
        addr_t          jump_target_id_i;
        addr_t          jump_target_ex_i;
        addr_t          mepc_i;
        trap_base_t     m_trap_base_addr_i;
        exc_cause_t     m_exc_vec_pc_mux_i;
        logic           instr_req_o;
        addr_t          instr_addr_o;
        logic           instr_gnt_i;
        logic           instr_rvalid_i;
        instr_t         instr_rdata_i;
        logic           id_ready_i;
        logic           instr_valid_id_o;
        instr_t         instr_rdata_id_o;
        addr_t          pc_id_o;
        logic           csr_mtvec_init_o;
        logic           if_busy_o;

        resp_t          resp_q [$];
        int unsigned    cyc = 0;
        int unsigned    last_due = 0;
        int unsigned    grant_delay = 1;
        addr_t          exp_pc;
        int             checks = 0;
        int             errors = 0;
        int             total_handovers = 0;
        logic           timed_out = 1'b0;

        if_stage u_if_stage (.*);

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        // Memory model records each grant with its response slot in request order
        always @(posedge clk) begin : grant_recorder
                resp_t          resp;
                int unsigned    due;
                if (!reset_i && instr_req_o && instr_gnt_i) begin
                        due = cyc + grant_delay;
                        if (due <= last_due) begin
                                due = last_due + 1;
                        end
                        last_due  = due;
                        resp.addr = instr_addr_o;
                        resp.due  = due;
                        resp_q.push_back(resp);
                end
                cyc = cyc + 1;
        end

        // Waits for the falling edge and drives the bus side of the memory model
        task automatic fall_edge();
                @(negedge clk);
                instr_gnt_i = ($urandom % 2) == 1;
                grant_delay = 1 + ($urandom % 3);
                if (resp_q.size() > 0 && resp_q[0].due == cyc) begin
                        instr_rvalid_i = 1'b1;
                        instr_rdata_i  = resp_q[0].addr ^ MEM_KEY;
                        void'(resp_q.pop_front());
                end else begin
                        instr_rvalid_i = 1'b0;
                        instr_rdata_i  = '0;
                end
        endtask

        task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                                   input string what);
                checks++;
                if (actual !== expected) begin
                        errors++;
                        $display("MISMATCH at time %0t: %s got %h, expected %h",
                                 $time, what, actual, expected);
                end
        endtask

        task automatic take_handover();
                check_equal(pc_id_o, exp_pc, "pc_id_o");
                check_equal(instr_rdata_id_o, exp_pc ^ MEM_KEY, "instr_rdata_id_o");
                exp_pc = exp_pc + 32'd4;
                total_handovers++;
        endtask

        // Trap base is the 24-bit field shifted up by eight bits
        function automatic addr_t expected_target(input row_t row);
                addr_t target;
                if (row.pc_mux == PC_EXCEPTION) begin
                        target = {row.operand[23:0], 8'h00};
                        if (row.exc_mux == EXC_PC_IRQ) begin
                                target = target + (addr_t'(row.cause) << 2);
                        end
                end else begin
                        target = row.operand;
                end
                return target & ~32'h3;
        endfunction

        task automatic collect(input row_t row, input int idx, output int got);
                int     idle;
                logic   hold_valid;
                addr_t  hold_pc;
                instr_t hold_rdata;
                got        = 0;
                idle       = 0;
                hold_valid = 1'b0;
                while (got < int'(row.count) && !timed_out) begin
                        @(posedge clk);
                        check_equal(32'(csr_mtvec_init_o), 32'd0, "csr_mtvec_init_o");
                        // Contents must not move after a stall on the previous edge
                        if (hold_valid) begin
                                check_equal(32'(instr_valid_id_o), 32'd1, "held valid");
                                check_equal(pc_id_o, hold_pc, "held pc_id_o");
                                check_equal(instr_rdata_id_o, hold_rdata, "held rdata");
                        end
                        hold_valid = instr_valid_id_o && !id_ready_i;
                        hold_pc    = pc_id_o;
                        hold_rdata = instr_rdata_id_o;
                        if (instr_valid_id_o && id_ready_i) begin
                                take_handover();
                                got++;
                                idle = 0;
                        end else begin
                                idle++;
                                if (idle > HANDOVER_TIMEOUT) begin
                                        $display("ERROR: row %0d got no handover for %0d cycles",
                                                 idx, idle);
                                        timed_out = 1'b1;
                                        errors++;
                                end
                        end
                        fall_edge();
                        id_ready_i = ($urandom % 100) < row.ready_pct;
                end
        endtask

        task automatic apply_row(input row_t row, input int idx);
                addr_t  target;
                int     got;
                int     errors_before;
                target        = expected_target(row);
                errors_before = errors;
                // Unselected sources carry junk so a wrong selection shows
                boot_addr_i        = $urandom;
                jump_target_id_i   = $urandom;
                jump_target_ex_i   = $urandom;
                mepc_i             = $urandom;
                m_trap_base_addr_i = trap_base_t'($urandom);
                m_exc_vec_pc_mux_i = exc_cause_t'($urandom);
                case (row.pc_mux)
                        PC_BOOT:      boot_addr_i = row.operand;
                        PC_JUMP:      jump_target_id_i = row.operand;
                        PC_BRANCH:    jump_target_ex_i = row.operand;
                        PC_MRET:      mepc_i = row.operand;
                        default: begin
                                m_trap_base_addr_i = row.operand[23:0];
                                m_exc_vec_pc_mux_i = row.cause;
                        end
                endcase
                pc_mux_i     = row.pc_mux;
                exc_pc_mux_i = row.exc_mux;
                pc_set_i     = 1'b1;
                id_ready_i   = 1'b0;
                @(posedge clk);
                check_equal(32'(csr_mtvec_init_o), 32'(row.pc_mux == PC_BOOT),
                            "csr_mtvec_init_o in redirect cycle");
                fall_edge();
                pc_set_i   = 1'b0;
                id_ready_i = ($urandom % 100) < row.ready_pct;
                exp_pc     = target;
                collect(row, idx, got);
                $display("row %0d: %s to %h, %0d of %0d handovers, %0d errors", idx,
                         row.pc_mux.name(), target, got, row.count, errors - errors_before);
        endtask

        // With req_i low the remaining words reach decode and the stage goes quiet
        task automatic drain_stream();
                int     waited;
                int     got;
                waited     = 0;
                got        = 0;
                req_i      = 1'b0;
                id_ready_i = 1'b1;
                while ((instr_req_o || if_busy_o || instr_valid_id_o) && !timed_out) begin
                        @(posedge clk);
                        if (instr_valid_id_o && id_ready_i) begin
                                take_handover();
                                got++;
                        end
                        waited++;
                        if (waited > DRAIN_TIMEOUT) begin
                                $display("ERROR: stage still busy after %0d cycles",
                                         waited);
                                timed_out = 1'b1;
                                errors++;
                        end
                        fall_edge();
                end
                repeat (20) begin
                        @(posedge clk);
                        check_equal(32'(instr_req_o), 32'd0, "instr_req_o after drain");
                        check_equal(32'(instr_valid_id_o), 32'd0, "instr_valid_id_o after drain");
                        check_equal(32'(if_busy_o), 32'd0, "if_busy_o after drain");
                        fall_edge();
                end
                $display("drain: %0d trailing handovers in %0d cycles", got, waited);
        endtask

        initial begin : main
                void'($urandom(32'h1cea));
                reset_i            = 1'b1;
                req_i              = 1'b0;
                pc_set_i           = 1'b0;
                pc_mux_i           = PC_BOOT;
                exc_pc_mux_i       = EXC_PC_EXCEPTION;
                boot_addr_i        = '0;
                jump_target_id_i   = '0;
                jump_target_ex_i   = '0;
                mepc_i             = '0;
                m_trap_base_addr_i = '0;
                m_exc_vec_pc_mux_i = '0;
                instr_gnt_i        = 1'b0;
                instr_rvalid_i     = 1'b0;
                instr_rdata_i      = '0;
                id_ready_i         = 1'b0;
                repeat (10) fall_edge();
                reset_i = 1'b0;
                req_i   = 1'b1;

                // Nothing moves before the first redirect
                repeat (8) begin
                        @(posedge clk);
                        check_equal(32'(instr_req_o), 32'd0, "instr_req_o before boot");
                        check_equal(32'(instr_valid_id_o), 32'd0, "instr_valid_id_o before boot");
                        check_equal(32'(csr_mtvec_init_o), 32'd0, "csr_mtvec_init_o before boot");
                        check_equal(32'(if_busy_o), 32'd0, "if_busy_o before boot");
                        fall_edge();
                end
                $display("reset: idle outputs checked, %0d errors", errors);

                for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
                        apply_row(ROWS[i], i);
                end
                if (!timed_out) begin
                        drain_stream();
                end

                $display("summary: %0d handovers, %0d checks, %0d errors",
                         total_handovers, checks, errors);
                if (errors == 0 && !timed_out) begin
                        $display("*** PASSED ***");
                end else begin
                        $display("*** FAILED ***");
                end
                $finish;
        end

endmodule

// File: all.f
design/if_pkg.sv
design/pc_select.sv
design/fetch_fifo.sv
design/prefetch_buffer.sv
design/if_id_register.sv
design/if_stage.sv
test/if_stage_asserts.sv
test/tb_if_stage.sv

// File: Makefile
# Verilator build and run of the instruction fetch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_if_stage
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/100ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG) || ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
